// File: lkp_settings.svh
// widths, table depth and control header constants for the lookup stage
// the action must be wider than one control beat and no wider than two,
// since an action entry arrives as a pair of beats
// the key must fit in one control beat, and the beat width is whole bytes
// LKP_IDX_W must cover LKP_DEPTH entries
`ifndef LKP_SETTINGS_SVH
`define LKP_SETTINGS_SVH

// data path widths
`define LKP_KEY_W 32
`define LKP_ACT_W 160
`define LKP_PHV_W 64
`define LKP_CTRL_W 128

// table geometry
`define LKP_DEPTH 16
`define LKP_IDX_W 4

// action issued on a miss
`define LKP_DEFAULT_ACT 63

// identity of this stage on the control stream
`define LKP_STAGE_ID 5'd0
`define LKP_LOOKUP_ID 3'd2
`define LKP_CTRL_FLAG 16'hF2F1

// control header layout
`define LKP_FLAG_LSB 64
`define LKP_RESV_KEY 4'd0

`endif

// File: lkp_pkg.sv
// types shared by the lookup stage blocks
// header field layout follows lkp_settings.svh, with the index at the top
// of the beat and the control flag starting at LKP_FLAG_LSB
// no functions here, only packed types

`include "lkp_settings.svh"

package lkp_pkg;

    // header view of a control beat
    typedef struct packed {
        logic [`LKP_IDX_W-1:0]                                 idx;
        logic [3:0]                                            resv;
        logic [4:0]                                            stage_id;
        logic [2:0]                                            lookup_id;
        logic [`LKP_CTRL_W-`LKP_IDX_W-12-16-`LKP_FLAG_LSB-1:0] pad_hi;
        logic [15:0]                                           flag;
        logic [`LKP_FLAG_LSB-1:0]                              pad_lo;
    } ctrl_hdr_t;

    // same beat read as a header or as raw payload
    typedef union packed {
        ctrl_hdr_t              hdr;
        logic [`LKP_CTRL_W-1:0] raw;
    } ctrl_word_u;

    typedef struct packed {
        ctrl_word_u data;
        logic       last;
        logic       valid;
    } ctrl_beat_t;

    // request from the key extractor, mask bit 1 is don't care
    typedef struct packed {
        logic [`LKP_KEY_W-1:0] key;
        logic [`LKP_KEY_W-1:0] mask;
        logic [`LKP_PHV_W-1:0] phv;
    } lookup_req_t;

    typedef struct packed {
        logic                  en;
        logic [`LKP_IDX_W-1:0] idx;
        logic [`LKP_KEY_W-1:0] key;
    } key_wr_t;

    typedef struct packed {
        logic                  en;
        logic [`LKP_IDX_W-1:0] idx;
        logic [`LKP_ACT_W-1:0] act;
    } act_wr_t;

endpackage

// File: ctrl_decoder.sv
// control stream filter for the lookup stage
// beats addressed to this stage are consumed and written into the tables,
// all other beats leave on c_out one cycle later, unchanged
// every beat seen while idle is checked for the address, so a foreign
// packet must not carry a header of this stage in a later beat
// no back-pressure, the source sends at most one beat per cycle

`include "lkp_settings.svh"

module ctrl_decoder import lkp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_beat_t c_in,
    output ctrl_beat_t c_out,
    output key_wr_t    key_wr,
    output act_wr_t    act_wr
);

    localparam int ACT_LO_W = `LKP_ACT_W - `LKP_CTRL_W;
    localparam int NBYTES   = `LKP_CTRL_W / 8;

    typedef enum logic [1:0] {
        S_IDLE,
        S_KEY,
        S_ACT_HI,
        S_ACT_LO
    } state_t;

    state_t                 state;
    logic [`LKP_CTRL_W-1:0] swapped;
    logic                   for_us;
    logic [`LKP_IDX_W-1:0]  next_idx;
    logic [`LKP_IDX_W-1:0]  wr_idx;
    logic                   key_en;
    logic                   act_en;
    logic [`LKP_KEY_W-1:0]  key_data;
    logic [`LKP_ACT_W-1:0]  act_data;
    ctrl_word_u             fwd_data;
    logic                   fwd_last;
    logic                   fwd_valid;

    // byte 0 of the beat ends up as the most significant byte
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            swapped[8*i +: 8] = c_in.data.raw[`LKP_CTRL_W-8-8*i +: 8];
        end
    end

    assign for_us = (c_in.data.hdr.stage_id == `LKP_STAGE_ID) &&
                    (c_in.data.hdr.lookup_id == `LKP_LOOKUP_ID) &&
                    (c_in.data.hdr.flag == `LKP_CTRL_FLAG);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            next_idx  <= '0;
            wr_idx    <= '0;
            key_en    <= 1'b0;
            act_en    <= 1'b0;
            fwd_valid <= 1'b0;
            fwd_last  <= 1'b0;
        end else begin
            key_en    <= 1'b0;
            act_en    <= 1'b0;
            fwd_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (c_in.valid && for_us) begin
                        next_idx <= c_in.data.hdr.idx;
                        state    <= (c_in.data.hdr.resv == `LKP_RESV_KEY) ? S_KEY : S_ACT_HI;
                    end else if (c_in.valid) begin
                        fwd_valid <= 1'b1;
                        fwd_last  <= c_in.last;
                    end
                end
                // one key per beat
                S_KEY: begin
                    if (c_in.valid) begin
                        key_en   <= 1'b1;
                        wr_idx   <= next_idx;
                        next_idx <= next_idx + 1'b1;
                        if (c_in.last) begin
                            state <= S_IDLE;
                        end
                    end
                end
                // upper part of an action, or a closing beat with no entry
                S_ACT_HI: begin
                    if (c_in.valid && c_in.last) begin
                        state <= S_IDLE;
                    end else if (c_in.valid) begin
                        state <= S_ACT_LO;
                    end
                end
                S_ACT_LO: begin
                    if (c_in.valid) begin
                        act_en   <= 1'b1;
                        wr_idx   <= next_idx;
                        next_idx <= next_idx + 1'b1;
                        state    <= c_in.last ? S_IDLE : S_ACT_HI;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // entry payloads are captured on the beat that carries them
    always_ff @(posedge clk) begin
        if (state == S_IDLE && c_in.valid) begin
            fwd_data <= c_in.data;
        end
        if (state == S_KEY && c_in.valid) begin
            key_data <= swapped[`LKP_CTRL_W-1 -: `LKP_KEY_W];
        end
        if (state == S_ACT_HI && c_in.valid) begin
            act_data[`LKP_ACT_W-1 -: `LKP_CTRL_W] <= swapped;
        end
        if (state == S_ACT_LO && c_in.valid) begin
            act_data[ACT_LO_W-1:0] <= swapped[`LKP_CTRL_W-1 -: ACT_LO_W];
        end
    end

    assign c_out  = '{data: fwd_data, last: fwd_last, valid: fwd_valid};
    assign key_wr = '{en: key_en, idx: wr_idx, key: key_data};
    assign act_wr = '{en: act_en, idx: wr_idx, act: act_data};

endmodule

// File: key_table.sv
// key store with a masked compare against every entry
// a mask bit of 1 ignores that key bit, the lowest matching index wins
// the compare is registered on every clock, whether or not a lookup is active
// an entry written at one edge takes part in the compare from the next edge

`include "lkp_settings.svh"

module key_table import lkp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  key_wr_t               key_wr,
    input  lookup_req_t           req,
    output logic                  match,
    output logic [`LKP_IDX_W-1:0] match_idx
);

    logic [`LKP_KEY_W-1:0] keys [`LKP_DEPTH];
    logic [`LKP_DEPTH-1:0] valid;
    logic [`LKP_DEPTH-1:0] hits;
    logic [`LKP_IDX_W-1:0] first_idx;

    always_ff @(posedge clk) begin
        if (key_wr.en) begin
            keys[key_wr.idx] <= key_wr.key;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (key_wr.en) begin
            valid[key_wr.idx] <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `LKP_DEPTH; i++) begin
            hits[i] = valid[i] && (((keys[i] ^ req.key) & ~req.mask) == '0);
        end
    end

    // scan downward so the lowest hit is the last one kept
    always_comb begin
        first_idx = '0;
        for (int i = `LKP_DEPTH - 1; i >= 0; i--) begin
            if (hits[i]) begin
                first_idx = `LKP_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match     <= 1'b0;
            match_idx <= '0;
        end else begin
            match     <= |hits;
            match_idx <= first_idx;
        end
    end

endmodule

// File: action_table.sv
// action store, one write port and one read port
// the read is registered on every clock, so rd_data follows rd_idx one cycle
// late; a read of the index being written returns the old word
// contents are undefined until written

`include "lkp_settings.svh"

module action_table import lkp_pkg::*; (
    input  logic                  clk,
    input  act_wr_t               act_wr,
    input  logic [`LKP_IDX_W-1:0] rd_idx,
    output logic [`LKP_ACT_W-1:0] rd_data
);

    logic [`LKP_ACT_W-1:0] mem [`LKP_DEPTH];

    always_ff @(posedge clk) begin
        if (act_wr.en) begin
            mem[act_wr.idx] <= act_wr.act;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

// File: lookup_ctrl.sv
// sequencing of one lookup from request to action
// a miss is answered one cycle after acceptance, a hit three cycles after,
// key_valid is ignored until the current lookup is finished
// the key table compare and the action table read run freely, so the
// result is taken on the exact cycle it belongs to this request

`include "lkp_settings.svh"

module lookup_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  key_valid,
    input  logic [`LKP_PHV_W-1:0] phv_in,
    input  logic                  match,
    input  logic [`LKP_ACT_W-1:0] act_rd,
    output logic [`LKP_ACT_W-1:0] action,
    output logic [`LKP_PHV_W-1:0] phv_out,
    output logic                  action_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_CMP,
        S_WAIT_RD,
        S_XFER
    } state_t;

    state_t                state;
    logic [`LKP_PHV_W-1:0] phv_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            action_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (key_valid) begin
                        state <= S_WAIT_CMP;
                    end
                end
                S_WAIT_CMP: begin
                    if (!match) begin
                        action_valid <= 1'b1;
                        state        <= S_IDLE;
                    end else begin
                        state <= S_WAIT_RD;
                    end
                end
                S_WAIT_RD: begin
                    state <= S_XFER;
                end
                default: begin
                    action_valid <= 1'b1;
                    state        <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && key_valid) begin
            phv_q <= phv_in;
        end
        // miss, default action right away
        if (state == S_WAIT_CMP && !match) begin
            action  <= `LKP_ACT_W'(`LKP_DEFAULT_ACT);
            phv_out <= phv_q;
        end
        // read launched with this request's index is on act_rd now
        if (state == S_WAIT_RD) begin
            action  <= act_rd;
            phv_out <= phv_q;
        end
    end

endmodule

// File: lookup_engine.sv
// match-action lookup stage, top level
// req is compared against the key table on every clock; key_valid starts a
// lookup only when the previous one has finished
// the control stream carries table writes for this stage, other packets
// pass through with one cycle of delay
// no back-pressure on any port

`include "lkp_settings.svh"

module lookup_engine import lkp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lookup_req_t           req,
    input  logic                  key_valid,
    input  ctrl_beat_t            c_in,
    output ctrl_beat_t            c_out,
    output logic [`LKP_ACT_W-1:0] action,
    output logic [`LKP_PHV_W-1:0] phv_out,
    output logic                  action_valid
);

    key_wr_t               key_wr;
    act_wr_t               act_wr;
    logic                  match;
    logic [`LKP_IDX_W-1:0] match_idx;
    logic [`LKP_ACT_W-1:0] act_rd;

    ctrl_decoder u_ctrl_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .c_in   (c_in),
        .c_out  (c_out),
        .key_wr (key_wr),
        .act_wr (act_wr)
    );

    key_table u_key_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_wr    (key_wr),
        .req       (req),
        .match     (match),
        .match_idx (match_idx)
    );

    // addressed straight from the registered compare
    action_table u_action_table (
        .clk     (clk),
        .act_wr  (act_wr),
        .rd_idx  (match_idx),
        .rd_data (act_rd)
    );

    lookup_ctrl u_lookup_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (req.phv),
        .match        (match),
        .act_rd       (act_rd),
        .action       (action),
        .phv_out      (phv_out),
        .action_valid (action_valid)
    );

endmodule

// File: tb_lookup_engine.sv
// directed testbench for the lookup stage
// keeps its own model of the key and action tables, built from the control
// packets it sends, and predicts each lookup result from that model
// inputs are driven 1 ns after the rising edge, outputs are sampled there too
// the run is stopped by a cycle limit if a test gets stuck

`include "lkp_settings.svh"

module tb_lookup_engine import lkp_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACT_LO_W   = `LKP_ACT_W - `LKP_CTRL_W;
    localparam int MAX_CYCLES = 3000;

    logic                  clk;
    logic                  rst_n;
    lookup_req_t           req;
    logic                  key_valid;
    ctrl_beat_t            c_in;
    ctrl_beat_t            c_out;
    logic [`LKP_ACT_W-1:0] action;
    logic [`LKP_PHV_W-1:0] phv_out;
    logic                  action_valid;

    // table model
    logic [`LKP_KEY_W-1:0] model_key [`LKP_DEPTH];
    logic                  model_kvalid [`LKP_DEPTH];
    logic [`LKP_ACT_W-1:0] model_act [`LKP_DEPTH];

    logic [`LKP_KEY_W-1:0] wr_keys [$];
    logic [`LKP_ACT_W-1:0] wr_acts [$];
    logic [31:0]           rng = 32'h6de6;
    logic                  fwd_window;
    int                    cycles = 0;
    int                    checks = 0;
    int                    errors = 0;
    int                    tests = 0;

    lookup_engine u_lookup_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .key_valid    (key_valid),
        .c_in         (c_in),
        .c_out        (c_out),
        .action       (action),
        .phv_out      (phv_out),
        .action_valid (action_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // nothing may leave on c_out outside a forwarding test
    always @(negedge clk) begin
        if (rst_n && c_out.valid && !fwd_window) begin
            $display("[ERROR] %0d ns: unexpected beat on c_out: %h", $time, c_out.data.raw);
            errors++;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // action word built from independent random words
    function automatic logic [`LKP_ACT_W-1:0] rand_action();
        logic [`LKP_ACT_W-1:0] a;
        a = '0;
        for (int i = 0; i < (`LKP_ACT_W + 31) / 32; i++) begin
            a = {a[`LKP_ACT_W-33:0], next_rand()};
        end
        return a;
    endfunction

    // payload bytes travel lowest byte first
    function automatic logic [`LKP_CTRL_W-1:0] byte_reverse(input logic [`LKP_CTRL_W-1:0] d);
        logic [`LKP_CTRL_W-1:0] r;
        for (int i = 0; i < `LKP_CTRL_W / 8; i++) begin
            r[8*i +: 8] = d[`LKP_CTRL_W-8-8*i +: 8];
        end
        return r;
    endfunction

    function automatic ctrl_word_u make_header(input logic [`LKP_IDX_W-1:0] idx,
                                               input logic [3:0] resv,
                                               input logic [4:0] stage,
                                               input logic [15:0] flag);
        ctrl_word_u w;
        w.raw           = '0;
        w.hdr.idx       = idx;
        w.hdr.resv      = resv;
        w.hdr.stage_id  = stage;
        w.hdr.lookup_id = `LKP_LOOKUP_ID;
        w.hdr.flag      = flag;
        return w;
    endfunction

    task automatic send_beat(input ctrl_word_u data, input logic last);
        @(posedge clk);
        #1;
        c_in = '{data: data, last: last, valid: 1'b1};
    endtask

    // drop valid, then leave room for the write to land
    task automatic idle_stream();
        @(posedge clk);
        #1;
        c_in = '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic send_key_entries(input logic [`LKP_IDX_W-1:0] start);
        ctrl_word_u            w;
        logic [`LKP_IDX_W-1:0] idx;
        idx = start;
        send_beat(make_header(start, `LKP_RESV_KEY, `LKP_STAGE_ID, `LKP_CTRL_FLAG), 1'b0);
        foreach (wr_keys[i]) begin
            w.raw = byte_reverse({wr_keys[i], {(`LKP_CTRL_W-`LKP_KEY_W){1'b0}}});
            send_beat(w, i == wr_keys.size() - 1);
            model_key[idx]    = wr_keys[i];
            model_kvalid[idx] = 1'b1;
            idx++;
        end
        idle_stream();
        wr_keys.delete();
    endtask

    // upper bits in the first beat, the rest at the top of the second
    task automatic send_action_entries(input logic [`LKP_IDX_W-1:0] start);
        ctrl_word_u            w;
        logic [`LKP_IDX_W-1:0] idx;
        idx = start;
        send_beat(make_header(start, 4'd1, `LKP_STAGE_ID, `LKP_CTRL_FLAG), 1'b0);
        foreach (wr_acts[i]) begin
            w.raw = byte_reverse(wr_acts[i][`LKP_ACT_W-1 -: `LKP_CTRL_W]);
            send_beat(w, 1'b0);
            w.raw = byte_reverse({wr_acts[i][ACT_LO_W-1:0], {(`LKP_CTRL_W-ACT_LO_W){1'b0}}});
            send_beat(w, i == wr_acts.size() - 1);
            model_act[idx] = wr_acts[i];
            idx++;
        end
        idle_stream();
        wr_acts.delete();
    endtask

    task automatic do_lookup(input logic [`LKP_KEY_W-1:0] key, input logic [`LKP_KEY_W-1:0] mask);
        logic [`LKP_PHV_W-1:0] phv;
        logic [`LKP_ACT_W-1:0] exp_act;
        logic                  found;
        logic                  got;
        phv     = {next_rand(), next_rand()};
        exp_act = `LKP_ACT_W'(`LKP_DEFAULT_ACT);
        found   = 1'b0;
        for (int i = 0; i < `LKP_DEPTH; i++) begin
            if (!found && model_kvalid[i] && ((model_key[i] ^ key) & ~mask) == '0) begin
                found   = 1'b1;
                exp_act = model_act[i];
            end
        end
        @(posedge clk);
        #1;
        req       = '{key: key, mask: mask, phv: phv};
        key_valid = 1'b1;
        @(posedge clk);
        #1;
        key_valid = 1'b0;
        got       = 1'b0;
        for (int n = 0; n < 8 && !got; n++) begin
            @(posedge clk);
            #1;
            got = action_valid;
        end
        checks++;
        if (!got) begin
            $display("%0d ns: lookup of key %h never raised action_valid", $time, key);
            errors++;
        end else if (action !== exp_act || phv_out !== phv) begin
            $display("[ERROR] %0d ns: key %h mask %h gave action %h phv %h, expected %h %h",
                     $time, key, mask, action, phv_out, exp_act, phv);
            errors++;
        end
    endtask

    task automatic forward_packet(input logic wrong_stage);
        ctrl_beat_t beats [4];
        if (wrong_stage) begin
            beats[0].data = make_header(4'd3, `LKP_RESV_KEY, 5'd7, `LKP_CTRL_FLAG);
        end else begin
            beats[0].data = make_header(4'd3, `LKP_RESV_KEY, `LKP_STAGE_ID, 16'h1234);
        end
        for (int i = 1; i < 4; i++) begin
            beats[i].data.raw      = {next_rand(), next_rand(), next_rand(), next_rand()};
            beats[i].data.hdr.flag = 16'h0000;
        end
        for (int i = 0; i < 4; i++) begin
            beats[i].last  = (i == 3);
            beats[i].valid = 1'b1;
        end
        fwd_window = 1'b1;
        @(posedge clk);
        #1;
        c_in = beats[0];
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            checks++;
            if (c_out !== beats[i]) begin
                $display("[ERROR] %0d ns: c_out beat %0d is %h, expected %h",
                         $time, i, c_out, beats[i]);
                errors++;
            end
            if (i < 3) begin
                c_in = beats[i+1];
            end else begin
                c_in = '0;
            end
        end
        @(posedge clk);
        #1;
        fwd_window = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic miss_before_writes();
        int e;
        e = errors;
        repeat (4) do_lookup(next_rand(), '0);
        report_test("default_action", e);
    endtask

    task automatic exact_and_masked_hits();
        int e;
        e = errors;
        repeat (4) wr_keys.push_back(next_rand());
        send_key_entries(4'd3);
        repeat (4) wr_acts.push_back(rand_action());
        send_action_entries(4'd3);
        for (int i = 3; i < 7; i++) begin
            do_lookup(model_key[i], '0);
        end
        do_lookup(model_key[4] ^ 32'h0000_0100, 32'h0000_0100);
        do_lookup(model_key[4] ^ 32'h0000_0100, '0);
        report_test("hits", e);
    endtask

    // entries 8 and 9 both match under the mask
    task automatic lowest_index_wins();
        int          e;
        logic [31:0] base;
        e    = errors;
        base = next_rand();
        wr_keys.push_back(base);
        wr_keys.push_back(base ^ 32'h1);
        send_key_entries(4'd8);
        repeat (2) wr_acts.push_back(rand_action());
        send_action_entries(4'd8);
        do_lookup(base ^ 32'h1, 32'h1);
        do_lookup(base ^ 32'h1, '0);
        report_test("priority", e);
    endtask

    task automatic foreign_packets_pass();
        int e;
        e = errors;
        forward_packet(1'b0);
        forward_packet(1'b1);
        do_lookup(model_key[3], '0);
        report_test("forwarding", e);
    endtask

    task automatic overwritten_entries();
        int          e;
        logic [31:0] old_key;
        e       = errors;
        old_key = model_key[5];
        wr_keys.push_back(next_rand());
        send_key_entries(4'd5);
        wr_acts.push_back(rand_action());
        send_action_entries(4'd4);
        do_lookup(model_key[5], '0);
        do_lookup(old_key, '0);
        do_lookup(model_key[4], '0);
        report_test("overwrite", e);
    endtask

    task automatic random_lookups();
        int          e;
        logic [31:0] r;
        logic [31:0] mask;
        logic [31:0] key;
        e = errors;
        repeat (`LKP_DEPTH) wr_keys.push_back(next_rand());
        send_key_entries(4'd0);
        repeat (`LKP_DEPTH) wr_acts.push_back(rand_action());
        send_action_entries(4'd0);
        repeat (40) begin
            r    = next_rand();
            mask = r[1] ? (next_rand() & next_rand()) : '0;
            key  = r[0] ? (model_key[r[7:4]] ^ (next_rand() & mask)) : next_rand();
            do_lookup(key, mask);
        end
        report_test("random_sweep", e);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        key_valid  = 1'b0;
        req        = '0;
        c_in       = '0;
        fwd_window = 1'b0;
        for (int i = 0; i < `LKP_DEPTH; i++) begin
            model_kvalid[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        miss_before_writes();
        exact_and_masked_hits();
        lowest_index_wins();
        foreign_packets_pass();
        overwritten_entries();
        random_lookups();
        repeat (4) @(posedge clk);
        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
lkp_pkg.sv
ctrl_decoder.sv
key_table.sv
action_table.sv
lookup_ctrl.sv
lookup_engine.sv
tb_lookup_engine.sv
